/* src/dram_settings.svh */
// Timing values are in controller clock cycles; DRAM_TRAS must be at least DRAM_TRCD + 2.
`ifndef DRAM_SETTINGS_SVH
`define DRAM_SETTINGS_SVH

// Minimum command spacings of the attached device.
`define DRAM_TRCD 3
`define DRAM_TRP 2
`define DRAM_TRAS 5
`define DRAM_TRFC 6
`define DRAM_TREFI 200

// Address split of a word address; the row field also carries the column.
`define DRAM_ROW_BITS 12
`define DRAM_BANK_BITS 2
`define DRAM_COL_BITS 8

`define DRAM_DATA_BITS 32
`define AXIL_ADDR_BITS 32

`endif

/* src/axil_pkg.sv */
// Host side types for a 32-bit AXI4-Lite slave; only OKAY and SLVERR responses are produced.
`default_nettype none

`include "dram_settings.svh"

package axil_pkg;

    typedef enum logic [1:0] {
        RESP_OKAY   = 2'b00,
        RESP_SLVERR = 2'b10
    } axil_resp_e;

    typedef struct packed {
        logic                       valid;
        logic [`AXIL_ADDR_BITS-1:0] addr;
    } axil_aw_t;

    typedef struct packed {
        logic                       valid;
        logic [`AXIL_ADDR_BITS-1:0] addr;
    } axil_ar_t;

    typedef struct packed {
        logic                           valid;
        logic [`DRAM_DATA_BITS/8-1:0]   strb;
        logic [`DRAM_DATA_BITS-1:0]     data;
    } axil_w_t;

    typedef struct packed {
        logic       valid;
        axil_resp_e resp;
    } axil_b_t;

    typedef struct packed {
        logic                       valid;
        axil_resp_e                 resp;
        logic [`DRAM_DATA_BITS-1:0] data;
    } axil_r_t;

endpackage

`default_nettype wire

/* src/dram_pkg.sv */
// Device side types; the column is carried zero-extended in the row-wide address field.
`default_nettype none

`include "dram_settings.svh"

package dram_pkg;

    localparam int WORD_BITS = `DRAM_ROW_BITS + `DRAM_BANK_BITS + `DRAM_COL_BITS;

    typedef enum logic [2:0] {
        CMD_NOP = 3'd0,
        CMD_ACT = 3'd1,
        CMD_RD  = 3'd2,
        CMD_WR  = 3'd3,
        CMD_PRE = 3'd4,
        CMD_REF = 3'd5
    } dram_cmd_e;

    // The strobe flag rides with the data so the output stage can judge the write.
    typedef struct packed {
        logic                       strb_full;
        logic [`DRAM_DATA_BITS-1:0] data;
    } dram_wdata_t;

    typedef struct packed {
        dram_cmd_e                  code;
        logic [`DRAM_BANK_BITS-1:0] bank;
        logic [`DRAM_ROW_BITS-1:0]  addr;
        dram_wdata_t                wdata;
    } dram_cmd_t;

    typedef struct packed {
        logic [`DRAM_ROW_BITS-1:0]  row;
        logic [`DRAM_BANK_BITS-1:0] bank;
        logic [`DRAM_COL_BITS-1:0]  col;
    } dram_fields_t;

    typedef union packed {
        logic [WORD_BITS-1:0] word;
        dram_fields_t         fields;
    } dram_addr_u;

    typedef struct packed {
        logic        write;
        dram_addr_u  addr;
        dram_wdata_t wdata;
    } access_req_t;

    localparam dram_cmd_t CMD_IDLE = '{code: CMD_NOP, bank: '0, addr: '0, wdata: '0};

endpackage

`default_nettype wire

/* src/axil_req_slave.sv */
// One transaction at a time; a write needs AW and W together and a read waits while either is up.
`default_nettype none

module axil_req_slave (
    input  logic                       clk,
    input  logic                       reset,
    input  axil_pkg::axil_aw_t         aw,
    input  axil_pkg::axil_w_t          w,
    input  axil_pkg::axil_ar_t         ar,
    output logic                       awready,
    output logic                       wready,
    output logic                       arready,
    output axil_pkg::axil_b_t          b,
    input  logic                       bready,
    output axil_pkg::axil_r_t          r,
    input  logic                       rready,
    output logic                       req_valid,
    input  logic                       req_ready,
    output dram_pkg::access_req_t      req,
    input  logic                       done_pulse,
    input  logic                       done_write,
    input  logic [`DRAM_DATA_BITS-1:0] rdata,
    input  axil_pkg::axil_resp_e       resp_code
);

    logic                       busy;
    logic                       write_go;
    logic                       read_go;
    logic                       b_valid;
    axil_pkg::axil_resp_e       b_resp;
    logic                       r_valid;
    axil_pkg::axil_resp_e       r_resp;
    logic [`DRAM_DATA_BITS-1:0] r_data;

    assign write_go = !busy && aw.valid && w.valid;
    assign read_go  = !busy && ar.valid && !aw.valid && !w.valid;

    assign awready = write_go;
    assign wready  = write_go;
    assign arready = read_go;

    assign b = '{valid: b_valid, resp: b_resp};
    assign r = '{valid: r_valid, resp: r_resp, data: r_data};

    // Busy covers the whole access, from acceptance until the host takes the response.
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            busy      <= 1'b0;
            req_valid <= 1'b0;
            b_valid   <= 1'b0;
            r_valid   <= 1'b0;
        end else begin
            if (write_go || read_go) begin
                busy      <= 1'b1;
                req_valid <= 1'b1;
            end else if (req_valid && req_ready) begin
                req_valid <= 1'b0;
            end
            if (done_pulse) begin
                b_valid <= done_write;
                r_valid <= !done_write;
            end
            if (b_valid && bready) begin
                b_valid <= 1'b0;
                busy    <= 1'b0;
            end
            if (r_valid && rready) begin
                r_valid <= 1'b0;
                busy    <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (write_go) begin
            req.write           <= 1'b1;
            req.addr.word       <= aw.addr[dram_pkg::WORD_BITS+1:2];
            req.wdata.strb_full <= &w.strb;
            req.wdata.data      <= w.data;
        end else if (read_go) begin
            req.write     <= 1'b0;
            req.addr.word <= ar.addr[dram_pkg::WORD_BITS+1:2];
            req.wdata     <= '0;
        end
        if (done_pulse) begin
            b_resp <= resp_code;
            r_resp <= resp_code;
            r_data <= rdata;
        end
    end

    a_req_held: assert property (@(posedge clk) disable iff (reset)
        req_valid && !req_ready |=> req_valid && $stable(req));

endmodule

`default_nettype wire

/* src/refresh_timer.sv */
// Raises refresh_req DRAM_TREFI cycles after reset or after the last acknowledge.
`default_nettype none

`include "dram_settings.svh"

module refresh_timer (
    input  logic clk,
    input  logic reset,
    output logic refresh_req,
    input  logic refresh_ack
);

    localparam int CNT_BITS = $clog2(`DRAM_TREFI + 1);

    logic [CNT_BITS-1:0] count;

    // The count stands still while a request waits for its acknowledge.
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            count       <= CNT_BITS'(`DRAM_TREFI);
            refresh_req <= 1'b0;
        end else if (refresh_req) begin
            if (refresh_ack) begin
                refresh_req <= 1'b0;
                count       <= CNT_BITS'(`DRAM_TREFI);
            end
        end else if (count == '0) begin
            refresh_req <= 1'b1;
        end else begin
            count <= count - 1'b1;
        end
    end

    a_ack_in_req: assert property (@(posedge clk) disable iff (reset)
        refresh_ack |-> refresh_req);

endmodule

`default_nettype wire

/* src/dram_sequencer.sv */
// Closed-page sequencer; refresh wins in idle, and DRAM_TRAS must be at least DRAM_TRCD + 2.
`default_nettype none

`include "dram_settings.svh"

module dram_sequencer (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  req_valid,
    output logic                  req_ready,
    input  dram_pkg::access_req_t req,
    input  logic                  refresh_req,
    output logic                  refresh_ack,
    output dram_pkg::dram_cmd_t   cmd,
    output logic                  done_pulse,
    output logic                  done_write
);

    localparam int CNT_BITS = $clog2(`DRAM_TRCD + `DRAM_TRAS + `DRAM_TRP + `DRAM_TRFC + 1);

    typedef enum logic [2:0] {
        IDLE,
        ACTIVATE_WAIT,
        COLUMN,
        RAS_WAIT,
        PRECHARGE_WAIT,
        REFRESH_PREP,
        REFRESH_ACTIVE
    } state_e;

    state_e                state;
    logic [CNT_BITS-1:0]   count;
    dram_pkg::access_req_t req_q;

    assign req_ready = (state == IDLE) && !refresh_req;

    // A count loaded with N-1 puts the next command N cycles after the current one.
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state       <= IDLE;
            count       <= '0;
            cmd         <= dram_pkg::CMD_IDLE;
            refresh_ack <= 1'b0;
            done_pulse  <= 1'b0;
            done_write  <= 1'b0;
        end else begin
            cmd.code    <= dram_pkg::CMD_NOP;
            refresh_ack <= 1'b0;
            done_pulse  <= 1'b0;
            if (count != '0) begin
                count <= count - 1'b1;
            end
            case (state)
                IDLE: begin
                    if (refresh_req && !refresh_ack) begin
                        state <= REFRESH_PREP;
                        count <= CNT_BITS'(`DRAM_TRP - 1);
                    end else if (req_valid && req_ready) begin
                        state    <= ACTIVATE_WAIT;
                        count    <= CNT_BITS'(`DRAM_TRCD - 1);
                        cmd.code <= dram_pkg::CMD_ACT;
                        cmd.bank <= req.addr.fields.bank;
                        cmd.addr <= req.addr.fields.row;
                    end
                end
                ACTIVATE_WAIT: begin
                    if (count == '0) begin
                        state     <= COLUMN;
                        cmd.code  <= req_q.write ? dram_pkg::CMD_WR : dram_pkg::CMD_RD;
                        cmd.addr  <= `DRAM_ROW_BITS'(req_q.addr.fields.col);
                        cmd.wdata <= req_q.wdata;
                    end
                end
                COLUMN: begin
                    state <= RAS_WAIT;
                    count <= CNT_BITS'(`DRAM_TRAS - `DRAM_TRCD - 2);
                end
                RAS_WAIT: begin
                    if (count == '0) begin
                        state    <= PRECHARGE_WAIT;
                        count    <= CNT_BITS'(`DRAM_TRP - 1);
                        cmd.code <= dram_pkg::CMD_PRE;
                    end
                end
                PRECHARGE_WAIT: begin
                    if (count == '0) begin
                        state      <= IDLE;
                        done_pulse <= 1'b1;
                        done_write <= req_q.write;
                    end
                end
                REFRESH_PREP: begin
                    if (count == '0) begin
                        state    <= REFRESH_ACTIVE;
                        count    <= CNT_BITS'(`DRAM_TRFC - 1);
                        cmd.code <= dram_pkg::CMD_REF;
                    end
                end
                REFRESH_ACTIVE: begin
                    if (count == '0) begin
                        state       <= IDLE;
                        refresh_ack <= 1'b1;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (req_valid && req_ready) begin
            req_q <= req;
        end
    end

    a_nop_after_cmd: assert property (@(posedge clk) disable iff (reset)
        cmd.code != dram_pkg::CMD_NOP |=> cmd.code == dram_pkg::CMD_NOP);

    a_act_spacing: assert property (@(posedge clk) disable iff (reset)
        cmd.code == dram_pkg::CMD_ACT |->
            ##(`DRAM_TRCD) cmd.code inside {dram_pkg::CMD_RD, dram_pkg::CMD_WR}
            ##(`DRAM_TRAS - `DRAM_TRCD) cmd.code == dram_pkg::CMD_PRE);

    // The acknowledge is one pulse that closes the tRFC window opened by REF.
    a_ack_pulse: assert property (@(posedge clk) disable iff (reset)
        refresh_ack |->
            ($past(cmd.code, `DRAM_TRFC) == dram_pkg::CMD_REF) ##1 !refresh_ack);

endmodule

`default_nettype wire

/* src/dram_cmd_phy.sv */
// Adds one register stage toward the pins; a partial-strobe write still reaches the device.
`default_nettype none

module dram_cmd_phy (
    input  logic                       clk,
    input  logic                       reset,
    input  dram_pkg::dram_cmd_t        cmd,
    output dram_pkg::dram_cmd_t        dram_cmd,
    input  logic [`DRAM_DATA_BITS-1:0] dram_rdata,
    output logic [`DRAM_DATA_BITS-1:0] rdata,
    output axil_pkg::axil_resp_e       resp_code
);

    logic rd_pending;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            dram_cmd   <= dram_pkg::CMD_IDLE;
            rd_pending <= 1'b0;
            resp_code  <= axil_pkg::RESP_OKAY;
        end else begin
            dram_cmd   <= cmd;
            rd_pending <= (dram_cmd.code == dram_pkg::CMD_RD);
            if (dram_cmd.code == dram_pkg::CMD_WR) begin
                resp_code <= dram_cmd.wdata.strb_full ? axil_pkg::RESP_OKAY
                                                      : axil_pkg::RESP_SLVERR;
            end else if (dram_cmd.code == dram_pkg::CMD_RD) begin
                resp_code <= axil_pkg::RESP_OKAY;
            end
        end
    end

    // The device answers one cycle after it sees RD on the pins.
    always_ff @(posedge clk) begin
        if (rd_pending) begin
            rdata <= dram_rdata;
        end
    end

endmodule

`default_nettype wire

/* src/dram_ctrl_top.sv */
// Single-rank closed-page controller; the host must keep wstrb all ones for a plain write.
`default_nettype none

module dram_ctrl_top (
    input  logic                       clk,
    input  logic                       reset,
    input  axil_pkg::axil_aw_t         aw,
    input  axil_pkg::axil_w_t          w,
    input  axil_pkg::axil_ar_t         ar,
    output logic                       awready,
    output logic                       wready,
    output logic                       arready,
    output axil_pkg::axil_b_t          b,
    input  logic                       bready,
    output axil_pkg::axil_r_t          r,
    input  logic                       rready,
    output dram_pkg::dram_cmd_t        dram_cmd,
    input  logic [`DRAM_DATA_BITS-1:0] dram_rdata
);

    logic                       req_valid;
    logic                       req_ready;
    dram_pkg::access_req_t      req;
    logic                       done_pulse;
    logic                       done_write;
    logic                       refresh_req;
    logic                       refresh_ack;
    dram_pkg::dram_cmd_t        cmd;
    logic [`DRAM_DATA_BITS-1:0] rdata;
    axil_pkg::axil_resp_e       resp_code;

    axil_req_slave slave0 (
        .clk(clk), .reset(reset),
        .aw(aw), .w(w), .ar(ar),
        .awready(awready), .wready(wready), .arready(arready),
        .b(b), .bready(bready), .r(r), .rready(rready),
        .req_valid(req_valid), .req_ready(req_ready), .req(req),
        .done_pulse(done_pulse), .done_write(done_write),
        .rdata(rdata), .resp_code(resp_code)
    );

    refresh_timer timer0 (
        .clk(clk), .reset(reset),
        .refresh_req(refresh_req), .refresh_ack(refresh_ack)
    );

    dram_sequencer seq0 (
        .clk(clk), .reset(reset),
        .req_valid(req_valid), .req_ready(req_ready), .req(req),
        .refresh_req(refresh_req), .refresh_ack(refresh_ack),
        .cmd(cmd), .done_pulse(done_pulse), .done_write(done_write)
    );

    dram_cmd_phy phy0 (
        .clk(clk), .reset(reset),
        .cmd(cmd), .dram_cmd(dram_cmd),
        .dram_rdata(dram_rdata), .rdata(rdata), .resp_code(resp_code)
    );

endmodule

`default_nettype wire

/* testbench/dram_model.sv */
// Behavioral single-rank device; PRE closes every bank and unwritten words read as zero.
`default_nettype none

`include "dram_settings.svh"

module dram_model (
    input  logic                       clk,
    input  logic                       reset,
    input  dram_pkg::dram_cmd_t        dram_cmd,
    output logic [`DRAM_DATA_BITS-1:0] dram_rdata,
    output int                         errors
);

    localparam int SAT = 255;

    logic [`DRAM_DATA_BITS-1:0]         mem [logic [dram_pkg::WORD_BITS-1:0]];
    logic [`DRAM_ROW_BITS-1:0]          open_row [2**`DRAM_BANK_BITS];
    logic [2**`DRAM_BANK_BITS-1:0]      row_open;
    logic [dram_pkg::WORD_BITS-1:0]     key;
    int                                 since_act;
    int                                 since_pre;
    int                                 since_ref;
    int                                 fails = 0;

    assign errors = fails;
    assign key = {open_row[dram_cmd.bank], dram_cmd.bank, dram_cmd.addr[`DRAM_COL_BITS-1:0]};

    // Each counter holds the cycles since its command was last seen on the pins.
    always @(posedge clk or posedge reset) begin
        if (reset) begin
            since_act  <= SAT;
            since_pre  <= SAT;
            since_ref  <= SAT;
            row_open   <= '0;
            dram_rdata <= '0;
        end else begin
            since_act <= (dram_cmd.code == dram_pkg::CMD_ACT) ? 1
                       : ((since_act < SAT) ? since_act + 1 : SAT);
            since_pre <= (dram_cmd.code == dram_pkg::CMD_PRE) ? 1
                       : ((since_pre < SAT) ? since_pre + 1 : SAT);
            since_ref <= (dram_cmd.code == dram_pkg::CMD_REF) ? 1
                       : ((since_ref < SAT) ? since_ref + 1 : SAT);
            case (dram_cmd.code)
                dram_pkg::CMD_ACT: begin
                    row_open[dram_cmd.bank] <= 1'b1;
                    open_row[dram_cmd.bank] <= dram_cmd.addr;
                end
                dram_pkg::CMD_PRE: row_open <= '0;
                dram_pkg::CMD_WR: mem[key] = dram_cmd.wdata.data;
                dram_pkg::CMD_RD: dram_rdata <= mem.exists(key) ? mem[key] : '0;
                default: ;
            endcase
        end
    end

    a_trcd: assert property (@(posedge clk) disable iff (reset)
        dram_cmd.code inside {dram_pkg::CMD_RD, dram_pkg::CMD_WR} |->
            since_act >= `DRAM_TRCD && row_open[dram_cmd.bank])
        else begin
            $display("Column command at %0t came %0d cycles after ACT or hit a closed bank",
                     $time, since_act);
            fails++;
        end

    a_tras: assert property (@(posedge clk) disable iff (reset)
        dram_cmd.code == dram_pkg::CMD_PRE |-> since_act >= `DRAM_TRAS)
        else begin
            $display("PRE at %0t came only %0d cycles after ACT", $time, since_act);
            fails++;
        end

    a_trp: assert property (@(posedge clk) disable iff (reset)
        dram_cmd.code inside {dram_pkg::CMD_ACT, dram_pkg::CMD_REF} |-> since_pre >= `DRAM_TRP)
        else begin
            $display("ACT or REF at %0t came only %0d cycles after PRE", $time, since_pre);
            fails++;
        end

    a_trfc: assert property (@(posedge clk) disable iff (reset)
        dram_cmd.code == dram_pkg::CMD_ACT |-> since_ref >= `DRAM_TRFC)
        else begin
            $display("ACT at %0t came only %0d cycles after REF", $time, since_ref);
            fails++;
        end

    // An ACT slipped in between the last PRE and a REF would leave a bank open here.
    a_ref_closed: assert property (@(posedge clk) disable iff (reset)
        dram_cmd.code == dram_pkg::CMD_REF |-> row_open == '0)
        else begin
            $display("REF at %0t was issued while a bank was still open", $time);
            fails++;
        end

endmodule

`default_nettype wire

/* testbench/tb_dram_ctrl.sv */
// Single-word AXI4-Lite traffic only; the random address pool never sets byte address bits 22 or 23.
`default_nettype none

`include "dram_settings.svh"

module tb_dram_ctrl;

    localparam int WAIT_LIMIT = 100;
    // One refresh interval plus a whole access and a whole refresh, with two cycles of slack.
    localparam int REF_GAP_MAX = `DRAM_TREFI + (`DRAM_TRAS + `DRAM_TRP + 2)
                               + (`DRAM_TRP + `DRAM_TRFC + 2) + 2;
    localparam int IDLE_CYCLES = 2 * `DRAM_TREFI + 40;
    localparam logic [31:0] ADDR_MASK = 32'h0030_0c1c;
    localparam int K_WRITE = 0;
    localparam int K_READ = 1;
    localparam int K_BVALID = 2;
    localparam int K_RVALID = 3;
    localparam int K_BTAKE = 4;
    localparam int K_RTAKE = 5;

    logic                                clk;
    logic                                reset;
    axil_pkg::axil_aw_t                  aw;
    axil_pkg::axil_w_t                   w;
    axil_pkg::axil_ar_t                  ar;
    logic                                awready;
    logic                                wready;
    logic                                arready;
    axil_pkg::axil_b_t                   b;
    logic                                bready;
    axil_pkg::axil_r_t                   r;
    logic                                rready;
    dram_pkg::dram_cmd_t                 dram_cmd;
    logic [`DRAM_DATA_BITS-1:0]          dram_rdata;
    int                                  model_fails;
    int                                  fails = 0;
    int                                  timeouts = 0;
    int                                  tests = 0;
    int                                  mark = 0;
    int                                  since_ref;
    int                                  ref_seen;
    logic [31:0]                         rng = 32'h525c_09b0;
    logic [31:0]                         ref_mem [logic [dram_pkg::WORD_BITS-1:0]];
    logic [31:0]                         addrs [16];
    axil_pkg::axil_resp_e                exp_bresp;
    logic [`DRAM_DATA_BITS-1:0]          exp_rdata;

    dram_ctrl_top dut0 (
        .clk(clk), .reset(reset),
        .aw(aw), .w(w), .ar(ar),
        .awready(awready), .wready(wready), .arready(arready),
        .b(b), .bready(bready), .r(r), .rready(rready),
        .dram_cmd(dram_cmd), .dram_rdata(dram_rdata)
    );

    dram_model model0 (
        .clk(clk), .reset(reset),
        .dram_cmd(dram_cmd), .dram_rdata(dram_rdata), .errors(model_fails)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            since_ref <= 0;
            ref_seen  <= 0;
        end else if (dram_cmd.code == dram_pkg::CMD_REF) begin
            since_ref <= 0;
            ref_seen  <= ref_seen + 1;
        end else begin
            since_ref <= since_ref + 1;
        end
    end

    function automatic logic [31:0] next_random();
        rng = rng ^ (rng << 13);
        rng = rng ^ (rng >> 17);
        rng = rng ^ (rng << 5);
        return rng;
    endfunction

    function automatic logic fired(input int kind);
        case (kind)
            K_WRITE:  return awready && wready;
            K_READ:   return arready;
            K_BVALID: return b.valid;
            K_RVALID: return r.valid;
            K_BTAKE:  return b.valid && bready;
            default:  return r.valid && rready;
        endcase
    endfunction

    task automatic wait_fire(input int kind, input string what);
        int n;
        n = 0;
        @(posedge clk);
        while (!fired(kind) && n < WAIT_LIMIT) begin
            @(posedge clk);
            n++;
        end
        if (!fired(kind)) begin
            $display("Timeout at %0t: no %s within %0d cycles", $time, what, WAIT_LIMIT);
            timeouts++;
        end
    endtask

    // A nonzero hold keeps the ready low for that many cycles after the response shows up.
    // Meanwhile the opposite kind of access to the same address waits on its channel.
    task automatic take_response(input logic is_write, input int hold,
                                 input logic [31:0] addr);
        logic [31:0] data;
        data = '0;
        if (hold > 0) begin
            bready = 1'b0;
            rready = 1'b0;
            wait_fire(is_write ? K_BVALID : K_RVALID, "response valid");
            @(negedge clk);
            if (is_write) begin
                ar = '{valid: 1'b1, addr: addr};
            end else begin
                data = next_random();
                aw = '{valid: 1'b1, addr: addr};
                w = '{valid: 1'b1, strb: 4'hf, data: data};
            end
            repeat (hold) @(negedge clk);
            bready = 1'b1;
            rready = 1'b1;
        end
        wait_fire(is_write ? K_BTAKE : K_RTAKE, "response handshake");
        if (hold > 0 && is_write) begin
            exp_rdata = ref_mem.exists(addr[23:2]) ? ref_mem[addr[23:2]] : '0;
            wait_fire(K_READ, "queued read address handshake");
            @(negedge clk);
            ar.valid = 1'b0;
            wait_fire(K_RTAKE, "queued read response handshake");
        end else if (hold > 0) begin
            exp_bresp = axil_pkg::RESP_OKAY;
            wait_fire(K_WRITE, "queued write address and data handshake");
            @(negedge clk);
            aw.valid = 1'b0;
            w.valid = 1'b0;
            ref_mem[addr[23:2]] = data;
            wait_fire(K_BTAKE, "queued write response handshake");
        end
    endtask

    task automatic write_word(input logic [31:0] addr, input logic [31:0] data,
                              input logic [3:0] strb, input int hold);
        @(negedge clk);
        aw = '{valid: 1'b1, addr: addr};
        w = '{valid: 1'b1, strb: strb, data: data};
        exp_bresp = (strb == 4'hf) ? axil_pkg::RESP_OKAY : axil_pkg::RESP_SLVERR;
        wait_fire(K_WRITE, "write address and data handshake");
        @(negedge clk);
        aw.valid = 1'b0;
        w.valid = 1'b0;
        if (strb == 4'hf) begin
            ref_mem[addr[23:2]] = data;
        end
        take_response(1'b1, hold, addr);
    endtask

    task automatic read_word(input logic [31:0] addr, input int hold);
        @(negedge clk);
        ar = '{valid: 1'b1, addr: addr};
        exp_rdata = ref_mem.exists(addr[23:2]) ? ref_mem[addr[23:2]] : '0;
        wait_fire(K_READ, "read address handshake");
        @(negedge clk);
        ar.valid = 1'b0;
        take_response(1'b0, hold, addr);
    endtask

    task automatic end_test(input string name);
        tests++;
        $display("test %0d %s: %0d new errors", tests, name,
                 fails + timeouts + model_fails - mark);
        mark = fails + timeouts + model_fails;
    endtask

    a_bresp: assert property (@(posedge clk) disable iff (reset)
        b.valid && bready |-> b.resp == exp_bresp)
        else begin
            $display("Mismatch at %0t: b.resp got %0h expected %0h", $time, b.resp, exp_bresp);
            fails++;
        end

    a_rdata: assert property (@(posedge clk) disable iff (reset)
        r.valid && rready |-> r.data == exp_rdata)
        else begin
            $display("Mismatch at %0t: r.data got %h expected %h", $time, r.data, exp_rdata);
            fails++;
        end

    a_rresp: assert property (@(posedge clk) disable iff (reset)
        r.valid && rready |-> r.resp == axil_pkg::RESP_OKAY)
        else begin
            $display("Mismatch at %0t: r.resp got %0h expected 0", $time, r.resp);
            fails++;
        end

    a_b_hold: assert property (@(posedge clk) disable iff (reset)
        b.valid && !bready |=> b.valid && $stable(b))
        else begin
            $display("Write response at %0t changed while bready was low", $time);
            fails++;
        end

    a_r_hold: assert property (@(posedge clk) disable iff (reset)
        r.valid && !rready |=> r.valid && $stable(r))
        else begin
            $display("Read response at %0t changed while rready was low", $time);
            fails++;
        end

    a_quiet: assert property (@(posedge clk) disable iff (reset)
        b.valid || r.valid |-> !awready && !wready && !arready)
        else begin
            $display("An address channel was ready at %0t while a response was held", $time);
            fails++;
        end

    a_ref_gap: assert property (@(posedge clk) disable iff (reset)
        since_ref <= REF_GAP_MAX)
        else begin
            $display("No REF for %0d cycles at %0t", since_ref, $time);
            fails++;
        end

    initial begin
        logic [31:0] addr;
        logic [31:0] rnd;
        int          hold;
        int          refs_before;
        reset = 1'b1;
        aw = '0;
        w = '0;
        ar = '0;
        bready = 1'b1;
        rready = 1'b1;
        exp_bresp = axil_pkg::RESP_OKAY;
        exp_rdata = '0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        for (int i = 0; i < 16; i++) begin
            addrs[i] = next_random() & ADDR_MASK;
            write_word(addrs[i], next_random(), 4'hf, 0);
        end
        write_word(addrs[3], next_random(), 4'hf, 0);
        for (int i = 0; i < 16; i++) begin
            read_word(addrs[i], 0);
        end
        for (int i = 0; i < 4; i++) begin
            read_word((next_random() & ADDR_MASK) | 32'h0040_0000, 0);
        end
        end_test("write then read");

        // Two full refresh intervals fit in the idle window.
        refs_before = ref_seen;
        repeat (IDLE_CYCLES) @(negedge clk);
        assert (ref_seen - refs_before >= 2)
            else begin
                $display("Only %0d REF commands in %0d idle cycles at %0t",
                         ref_seen - refs_before, IDLE_CYCLES, $time);
                fails++;
            end
        end_test("refresh cadence");

        for (int i = 0; i < 80; i++) begin
            addr = next_random() & ADDR_MASK;
            rnd = next_random();
            if (rnd[1:0] == 2'b00) begin
                read_word(addr, 0);
            end else begin
                write_word(addr, next_random(), 4'hf, 0);
            end
        end
        end_test("refresh during traffic");

        for (int i = 0; i < 12; i++) begin
            addr = next_random() & ADDR_MASK;
            rnd = next_random();
            hold = 1 + int'(rnd[2:0]);
            if (i % 2 == 0) begin
                write_word(addr, next_random(), 4'hf, hold);
            end else begin
                read_word(addr, hold);
            end
        end
        end_test("response back-pressure");

        write_word(32'h0080_0000, next_random(), 4'b1011, 0);
        write_word(32'h0080_0004, next_random(), 4'b0000, 0);
        write_word(next_random() & ADDR_MASK, next_random(), 4'hf, 0);
        end_test("partial strobe");

        tests++;
        $display("test %0d command timing: %0d violations over the run", tests, model_fails);
        $display("%0d tests, %0d check failures, %0d timing violations, %0d timeouts",
                 tests, fails, model_fails, timeouts);
        if (fails + model_fails + timeouts == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* dram_ctrl.f */
+incdir+src
src/axil_pkg.sv
src/dram_pkg.sv
src/axil_req_slave.sv
src/refresh_timer.sv
src/dram_sequencer.sv
src/dram_cmd_phy.sv
src/dram_ctrl_top.sv
testbench/dram_model.sv
testbench/tb_dram_ctrl.sv

/* run_sim.sh */
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -j 0 -f dram_ctrl.f --top-module tb_dram_ctrl -o sim_tb \
    || exit 1
out="$(./obj_dir/sim_tb)"
echo "$out"
echo "$out" | grep -qx "TB PASSED" && exit 0 || exit 1
